//--- hw/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// data word and byte address
`define MIPS_DATA_W 32

// register index, 32 entries
`define MIPS_REG_AW 5
`define MIPS_REG_NUM (1 << `MIPS_REG_AW)

//////////////////////////////////////////////////
// memory depths, in words
//////////////////////////////////////////////////

`define MIPS_IMEM_AW 7
`define MIPS_IMEM_DEPTH (1 << `MIPS_IMEM_AW)

`define MIPS_DMEM_AW 7
`define MIPS_DMEM_DEPTH (1 << `MIPS_DMEM_AW)

`endif

//--- hw/mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		OP_HALT  = 6'h3f
	} opcode_e;

	// r-type function codes, instr[5:0]
	typedef enum logic [5:0] {
		F_SLL = 6'h00,
		F_JR  = 6'h08,
		F_ADD = 6'h20,
		F_SUB = 6'h22,
		F_AND = 6'h24,
		F_OR  = 6'h25,
		F_SLT = 6'h2a
	} funct_e;

	// add is zero so a cleared bus is a harmless add
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL
	} alu_op_e;

	//////////////////////////////////////////////////
	// control buses
	//////////////////////////////////////////////////

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    reg_dst_rd;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_write;
		logic branch;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	//////////////////////////////////////////////////
	// stage registers
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [`MIPS_DATA_W-1:0] pc_plus4;
		logic [`MIPS_DATA_W-1:0] instr;
	} if_id_t;

	typedef struct packed {
		ex_ctrl_t                ex;
		mem_ctrl_t               mem;
		wb_ctrl_t                wb;
		logic [`MIPS_DATA_W-1:0] pc_plus4;
		logic [`MIPS_DATA_W-1:0] rs_val;
		logic [`MIPS_DATA_W-1:0] rt_val;
		logic [`MIPS_DATA_W-1:0] imm;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [`MIPS_REG_AW-1:0] rd;
		logic [`MIPS_REG_AW-1:0] shamt;
		logic                    halt;
	} id_ex_t;

	typedef struct packed {
		mem_ctrl_t               mem;
		wb_ctrl_t                wb;
		logic [`MIPS_DATA_W-1:0] alu_result;
		logic                    zero;
		logic [`MIPS_DATA_W-1:0] store_data;
		logic [`MIPS_DATA_W-1:0] branch_target;
		logic [`MIPS_REG_AW-1:0] dest;
		logic                    halt;
	} ex_mem_t;

	typedef struct packed {
		wb_ctrl_t                wb;
		logic [`MIPS_DATA_W-1:0] read_data;
		logic [`MIPS_DATA_W-1:0] alu_result;
		logic [`MIPS_REG_AW-1:0] dest;
		logic                    halt;
	} mem_wb_t;

endpackage

//--- hw/fetch_stage.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module fetch_stage (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     stall,
	input  logic                     jump,
	input  logic                     jump_register,
	input  logic [`MIPS_DATA_W-1:0]  jump_target,
	input  logic [`MIPS_DATA_W-1:0]  jr_target,
	input  logic                     branch_taken,
	input  logic [`MIPS_DATA_W-1:0]  branch_target,
	input  logic                     halt_seen,
	input  logic                     debug_flag,
	input  logic                     imem_we,
	input  logic [`MIPS_IMEM_AW-1:0] imem_addr,
	input  logic [`MIPS_DATA_W-1:0]  imem_data,
	output mips_pkg::if_id_t         if_id,
	output logic [`MIPS_DATA_W-1:0]  pc
);

	logic [`MIPS_DATA_W-1:0]  imem [0:`MIPS_IMEM_DEPTH-1];
	logic [`MIPS_DATA_W-1:0]  pc_plus4;
	logic [`MIPS_DATA_W-1:0]  pc_next;
	logic [`MIPS_IMEM_AW-1:0] pc_idx;
	logic                     pc_hold;

	assign pc_plus4 = pc + `MIPS_DATA_W'(4);
	// word index into instruction memory
	assign pc_idx = pc[`MIPS_IMEM_AW+1:2];

	// branch from memory is the oldest redirect and wins
	assign pc_next = branch_taken ? branch_target :
		jump_register ? jr_target :
		jump ? jump_target : pc_plus4;

	// debug load or halt
	assign pc_hold = debug_flag || halt_seen;

	//////////////////////////////////////////////////
	// instruction memory with debug write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_data;
		end
	end

	//////////////////////////////////////////////////
	// pc and fetch/decode register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			pc    <= '0;
			if_id <= '0;
		end else if (branch_taken) begin
			// three younger instructions dropped
			pc    <= pc_next;
			if_id <= '0;
		end else if (stall) begin
			// keep pc and the waiting instruction
			pc    <= pc;
			if_id <= if_id;
		end else if (pc_hold) begin
			// feed bubbles while held
			pc    <= pc;
			if_id <= '0;
		end else begin
			pc <= pc_next;
			// j / jr cancel the slot behind them
			if (jump || jump_register) begin
				if_id <= '0;
			end else begin
				if_id.pc_plus4 <= pc_plus4;
				if_id.instr    <= imem[pc_idx];
			end
		end
	end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module decode_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  mips_pkg::if_id_t        if_id,
	input  logic                    wb_we,
	input  logic [`MIPS_REG_AW-1:0] wb_reg,
	input  logic [`MIPS_DATA_W-1:0] wb_data,
	input  logic                    branch_taken,
	input  logic [`MIPS_REG_AW-1:0] dbg_reg_sel,
	output mips_pkg::id_ex_t        id_ex,
	output logic                    stall,
	output logic                    jump,
	output logic                    jump_register,
	output logic [`MIPS_DATA_W-1:0] jump_target,
	output logic [`MIPS_DATA_W-1:0] jr_target,
	output logic                    halt_seen,
	output logic [`MIPS_DATA_W-1:0] dbg_reg_data
);
	import mips_pkg::*;

	opcode_e                 op;
	funct_e                  funct;
	logic [`MIPS_REG_AW-1:0] rs, rt, rd, shamt;
	logic [`MIPS_DATA_W-1:0] imm_ext, rs_val, rt_val;
	ex_ctrl_t                ex_ctrl;
	mem_ctrl_t               mem_ctrl;
	wb_ctrl_t                wb_ctrl;
	logic                    is_jump, is_jr, is_halt, reads_rs, reads_rt;
	logic                    halt_q;
	logic [`MIPS_DATA_W-1:0] regs [0:`MIPS_REG_NUM-1];

	// instruction fields
	assign op      = opcode_e'(if_id.instr[31:26]);
	assign funct   = funct_e'(if_id.instr[5:0]);
	assign rs      = if_id.instr[25:21];
	assign rt      = if_id.instr[20:16];
	assign rd      = if_id.instr[15:11];
	assign shamt   = if_id.instr[10:6];
	assign imm_ext = {{(`MIPS_DATA_W-16){if_id.instr[15]}}, if_id.instr[15:0]};

	//////////////////////////////////////////////////
	// main control
	//////////////////////////////////////////////////

	always_comb begin
		ex_ctrl  = '0;
		mem_ctrl = '0;
		wb_ctrl  = '0;
		is_jump  = 1'b0;
		is_jr    = 1'b0;
		is_halt  = 1'b0;
		reads_rs = 1'b0;
		reads_rt = 1'b0;
		case (op)
			OP_RTYPE: begin
				ex_ctrl.reg_dst_rd = 1'b1;
				wb_ctrl.reg_write  = 1'b1;
				reads_rs           = 1'b1;
				reads_rt           = 1'b1;
				case (funct)
					F_ADD: ex_ctrl.alu_op = ALU_ADD;
					F_SUB: ex_ctrl.alu_op = ALU_SUB;
					F_AND: ex_ctrl.alu_op = ALU_AND;
					F_OR:  ex_ctrl.alu_op = ALU_OR;
					F_SLT: ex_ctrl.alu_op = ALU_SLT;
					F_SLL: ex_ctrl.alu_op = ALU_SLL;
					F_JR: begin
						// no writeback, target taken from rs here
						wb_ctrl.reg_write = 1'b0;
						is_jr             = 1'b1;
					end
					// unknown funct runs as a nop
					default: wb_ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				ex_ctrl.alu_src_imm = 1'b1;
				wb_ctrl.reg_write   = 1'b1;
				reads_rs            = 1'b1;
			end
			OP_LW: begin
				ex_ctrl.alu_src_imm = 1'b1;
				wb_ctrl.reg_write   = 1'b1;
				wb_ctrl.mem_to_reg  = 1'b1;
				reads_rs            = 1'b1;
			end
			OP_SW: begin
				ex_ctrl.alu_src_imm = 1'b1;
				mem_ctrl.mem_write  = 1'b1;
				reads_rs            = 1'b1;
				reads_rt            = 1'b1;
			end
			OP_BEQ: begin
				// compared by subtraction, zero flag decides in memory
				ex_ctrl.alu_op  = ALU_SUB;
				mem_ctrl.branch = 1'b1;
				reads_rs        = 1'b1;
				reads_rt        = 1'b1;
			end
			OP_J:    is_jump = 1'b1;
			OP_HALT: is_halt = 1'b1;
			default: ;
		endcase
	end

	//////////////////////////////////////////////////
	// register file
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wb_we && (wb_reg != '0)) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// r0 reads zero, writeback bypasses the array
	assign rs_val = (rs == '0) ? '0 : (wb_we && (wb_reg == rs)) ? wb_data : regs[rs];
	assign rt_val = (rt == '0) ? '0 : (wb_we && (wb_reg == rt)) ? wb_data : regs[rt];
	assign dbg_reg_data = (dbg_reg_sel == '0) ? '0 : regs[dbg_reg_sel];

	// load in execute whose rt feeds this instruction
	assign stall = id_ex.wb.mem_to_reg && (id_ex.rt != '0) &&
		((reads_rs && (id_ex.rt == rs)) || (reads_rt && (id_ex.rt == rt)));

	// jumps wait out a stall like anything else
	assign jump          = is_jump && !stall;
	assign jump_register = is_jr && !stall;
	assign jump_target   = {if_id.pc_plus4[`MIPS_DATA_W-1 -: 4], if_id.instr[25:0], 2'b00};
	assign jr_target     = rs_val;

	// halt is dropped again if an older branch flushes it
	always_ff @(posedge clk) begin
		if (rst || branch_taken) begin
			halt_q <= 1'b0;
		end else if (is_halt) begin
			halt_q <= 1'b1;
		end
	end
	assign halt_seen = halt_q || (is_halt && !branch_taken);

	// decode/execute register, bubble on stall or branch
	always_ff @(posedge clk) begin
		if (rst || stall || branch_taken) begin
			id_ex <= '0;
		end else begin
			id_ex.ex       <= ex_ctrl;
			id_ex.mem      <= mem_ctrl;
			id_ex.wb       <= wb_ctrl;
			id_ex.pc_plus4 <= if_id.pc_plus4;
			id_ex.rs_val   <= rs_val;
			id_ex.rt_val   <= rt_val;
			id_ex.imm      <= imm_ext;
			id_ex.rs       <= rs;
			id_ex.rt       <= rt;
			id_ex.rd       <= rd;
			id_ex.shamt    <= shamt;
			id_ex.halt     <= is_halt;
		end
	end

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module execute_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  mips_pkg::id_ex_t        id_ex,
	input  logic                    fwd_mem_we,
	input  logic [`MIPS_REG_AW-1:0] fwd_mem_reg,
	input  logic [`MIPS_DATA_W-1:0] fwd_mem_data,
	input  logic                    wb_we,
	input  logic [`MIPS_REG_AW-1:0] wb_reg,
	input  logic [`MIPS_DATA_W-1:0] wb_data,
	input  logic                    branch_taken,
	output mips_pkg::ex_mem_t       ex_mem
);
	import mips_pkg::*;

	logic [`MIPS_DATA_W-1:0] op_a, op_b, alu_b, alu_y;
	logic [`MIPS_DATA_W-1:0] br_target;
	logic [`MIPS_REG_AW-1:0] dest;

	// newest producer first, r0 never forwarded
	function automatic logic [`MIPS_DATA_W-1:0] fwd_sel(
		input logic [`MIPS_REG_AW-1:0] src,
		input logic [`MIPS_DATA_W-1:0] reg_val
	);
		if (fwd_mem_we && (fwd_mem_reg != '0) && (fwd_mem_reg == src)) begin
			return fwd_mem_data;
		end
		if (wb_we && (wb_reg != '0) && (wb_reg == src)) begin
			return wb_data;
		end
		return reg_val;
	endfunction

	//////////////////////////////////////////////////
	// operand select and alu
	//////////////////////////////////////////////////

	always_comb begin
		op_a = fwd_sel(id_ex.rs, id_ex.rs_val);
		op_b = fwd_sel(id_ex.rt, id_ex.rt_val);
	end

	// immediate for addi, lw, sw
	assign alu_b = id_ex.ex.alu_src_imm ? id_ex.imm : op_b;

	always_comb begin
		case (id_ex.ex.alu_op)
			ALU_ADD: alu_y = op_a + alu_b;
			ALU_SUB: alu_y = op_a - alu_b;
			ALU_AND: alu_y = op_a & alu_b;
			ALU_OR:  alu_y = op_a | alu_b;
			ALU_SLT: alu_y = {{(`MIPS_DATA_W-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			// sll shifts rt by shamt
			ALU_SLL: alu_y = op_b << id_ex.shamt;
			default: alu_y = '0;
		endcase
	end

	// word offset from pc+4
	assign br_target = id_ex.pc_plus4 + {id_ex.imm[`MIPS_DATA_W-3:0], 2'b00};
	assign dest      = id_ex.ex.reg_dst_rd ? id_ex.rd : id_ex.rt;

	// execute/memory register
	always_ff @(posedge clk) begin
		if (rst || branch_taken) begin
			ex_mem <= '0;
		end else begin
			ex_mem.mem           <= id_ex.mem;
			ex_mem.wb            <= id_ex.wb;
			ex_mem.alu_result    <= alu_y;
			ex_mem.zero          <= (alu_y == '0);
			// store data also needs forwarding
			ex_mem.store_data    <= op_b;
			ex_mem.branch_target <= br_target;
			ex_mem.dest          <= dest;
			ex_mem.halt          <= id_ex.halt;
		end
	end

endmodule

//--- hw/memory_stage.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module memory_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  mips_pkg::ex_mem_t       ex_mem,
	input  logic                    dbg_mem_en,
	input  logic [`MIPS_DATA_W-1:0] dbg_mem_addr,
	output mips_pkg::mem_wb_t       mem_wb,
	output logic                    branch_taken,
	output logic [`MIPS_DATA_W-1:0] branch_target,
	output logic [`MIPS_DATA_W-1:0] read_data
);

	logic [`MIPS_DATA_W-1:0]  dmem [0:`MIPS_DMEM_DEPTH-1];
	logic [`MIPS_DATA_W-1:0]  mem_addr;
	logic [`MIPS_DMEM_AW-1:0] mem_idx;

	//////////////////////////////////////////////////
	// address select and data memory
	//////////////////////////////////////////////////

	// debug readback takes over the address
	assign mem_addr = dbg_mem_en ? dbg_mem_addr : ex_mem.alu_result;
	assign mem_idx  = mem_addr[`MIPS_DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (ex_mem.mem.mem_write && !dbg_mem_en) begin
			dmem[mem_idx] <= ex_mem.store_data;
		end
	end

	// beq taken when rs - rt was zero
	assign branch_taken  = ex_mem.mem.branch && ex_mem.zero;
	assign branch_target = ex_mem.branch_target;

	//////////////////////////////////////////////////
	// memory/writeback register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb <= '0;
		end else begin
			mem_wb.wb         <= ex_mem.wb;
			// synchronous read lands here
			mem_wb.read_data  <= dmem[mem_idx];
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.dest       <= ex_mem.dest;
			// sticky, stays up until reset
			mem_wb.halt       <= mem_wb.halt || ex_mem.halt;
		end
	end

	// same word for writeback and debug readback
	assign read_data = mem_wb.read_data;

endmodule

//--- hw/mips_pipeline_top.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_pipeline_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     debug_flag,
	input  logic                     wea_ram_inst,
	input  logic [`MIPS_IMEM_AW-1:0] imem_addr,
	input  logic [`MIPS_DATA_W-1:0]  imem_data,
	input  logic [`MIPS_REG_AW-1:0]  dbg_reg_sel,
	input  logic                     dbg_mem_en,
	input  logic [`MIPS_DATA_W-1:0]  dbg_mem_addr,
	output logic [`MIPS_DATA_W-1:0]  pc,
	output logic [`MIPS_DATA_W-1:0]  dbg_reg_data,
	output logic [`MIPS_DATA_W-1:0]  dbg_mem_data,
	output logic                     halt_flag
);
	import mips_pkg::*;

	// stage registers
	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	// feedback to fetch and decode
	logic                    stall, jump, jump_register, halt_seen;
	logic                    branch_taken;
	logic [`MIPS_DATA_W-1:0] jump_target, jr_target, branch_target;

	// writeback and forwarding
	logic                    wb_we, fwd_mem_we;
	logic [`MIPS_REG_AW-1:0] wb_reg;
	logic [`MIPS_DATA_W-1:0] wb_data;

	//////////////////////////////////////////////////
	// writeback select
	//////////////////////////////////////////////////

	assign wb_data = mem_wb.wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;
	assign wb_we   = mem_wb.wb.reg_write;
	assign wb_reg  = mem_wb.dest;

	// a load in memory has no data yet, the stall covers it
	assign fwd_mem_we = ex_mem.wb.reg_write && !ex_mem.wb.mem_to_reg;
	assign halt_flag  = mem_wb.halt;

	fetch_stage u_fetch (
		.clk(clk), .rst(rst), .stall(stall),
		.jump(jump), .jump_register(jump_register),
		.jump_target(jump_target), .jr_target(jr_target),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.halt_seen(halt_seen), .debug_flag(debug_flag),
		.imem_we(wea_ram_inst), .imem_addr(imem_addr), .imem_data(imem_data),
		.if_id(if_id), .pc(pc)
	);

	decode_stage u_decode (
		.clk(clk), .rst(rst), .if_id(if_id),
		.wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data),
		.branch_taken(branch_taken), .dbg_reg_sel(dbg_reg_sel),
		.id_ex(id_ex), .stall(stall),
		.jump(jump), .jump_register(jump_register),
		.jump_target(jump_target), .jr_target(jr_target),
		.halt_seen(halt_seen), .dbg_reg_data(dbg_reg_data)
	);

	execute_stage u_execute (
		.clk(clk), .rst(rst), .id_ex(id_ex),
		.fwd_mem_we(fwd_mem_we), .fwd_mem_reg(ex_mem.dest),
		.fwd_mem_data(ex_mem.alu_result),
		.wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data),
		.branch_taken(branch_taken), .ex_mem(ex_mem)
	);

	memory_stage u_memory (
		.clk(clk), .rst(rst), .ex_mem(ex_mem),
		.dbg_mem_en(dbg_mem_en), .dbg_mem_addr(dbg_mem_addr),
		.mem_wb(mem_wb), .branch_taken(branch_taken),
		.branch_target(branch_target), .read_data(dbg_mem_data)
	);

endmodule

//--- test/mips_sva.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_sva (
	input logic                    clk,
	input logic                    rst,
	input logic                    debug_flag,
	input logic [`MIPS_DATA_W-1:0] pc,
	input logic                    halt_flag,
	input logic [`MIPS_REG_AW-1:0] dbg_reg_sel,
	input logic [`MIPS_DATA_W-1:0] dbg_reg_data
);

	// failure tally, read out at the end of the run
	int fail_count = 0;

	//////////////////////////////////////////////////
	// reset and halt
	//////////////////////////////////////////////////

	a_reset_state: assert property (@(posedge clk) rst |=> (pc == '0 && !halt_flag))
		else begin
			$error("pc or halt_flag not cleared by reset");
			fail_count++;
		end

	// sticky until reset
	a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halt_flag |=> halt_flag)
		else begin
			$error("halt_flag dropped while out of reset");
			fail_count++;
		end

	a_pc_frozen: assert property (@(posedge clk) disable iff (rst) halt_flag |=> $stable(pc))
		else begin
			$error("pc moved after halt");
			fail_count++;
		end

	//////////////////////////////////////////////////
	// debug port
	//////////////////////////////////////////////////

	// program load holds the pc
	a_debug_hold: assert property (@(posedge clk) disable iff (rst) debug_flag |=> $stable(pc))
		else begin
			$error("pc moved while debug_flag was high");
			fail_count++;
		end

	a_r0_zero: assert property (@(posedge clk) disable iff (rst)
		(dbg_reg_sel == '0) |-> (dbg_reg_data == '0))
		else begin
			$error("register 0 read back nonzero");
			fail_count++;
		end

endmodule

bind mips_pipeline_top mips_sva u_mips_sva (
	.clk(clk), .rst(rst), .debug_flag(debug_flag), .pc(pc), .halt_flag(halt_flag),
	.dbg_reg_sel(dbg_reg_sel), .dbg_reg_data(dbg_reg_data)
);

//--- test/mips_tb.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_tb;
	import mips_pkg::*;

	localparam int PROG_LEN       = 25;
	localparam int LOAD_WORDS     = 32;
	localparam int MEM_CHECK      = 4;
	// program length times a wide margin
	localparam int TIMEOUT_CYCLES = PROG_LEN * 80;

	logic                     clk;
	logic                     rst;
	logic                     debug_flag;
	logic                     wea_ram_inst;
	logic [`MIPS_IMEM_AW-1:0] imem_addr;
	logic [`MIPS_DATA_W-1:0]  imem_data;
	logic [`MIPS_REG_AW-1:0]  dbg_reg_sel;
	logic                     dbg_mem_en;
	logic [`MIPS_DATA_W-1:0]  dbg_mem_addr;
	logic [`MIPS_DATA_W-1:0]  pc;
	logic [`MIPS_DATA_W-1:0]  dbg_reg_data;
	logic [`MIPS_DATA_W-1:0]  dbg_mem_data;
	logic                     halt_flag;

	logic [`MIPS_DATA_W-1:0] prog [0:LOAD_WORDS-1];
	logic [`MIPS_DATA_W-1:0] exp_reg [0:`MIPS_REG_NUM-1];
	logic [`MIPS_DATA_W-1:0] exp_mem [0:MEM_CHECK-1];
	bit                      reg_known [0:`MIPS_REG_NUM-1];
	bit                      mem_known [0:MEM_CHECK-1];
	logic [`MIPS_DATA_W-1:0] halt_pc;
	int                      errors = 0;
	int                      cycles = 0;
	int                      sva_fails;

	mips_pipeline_top i_mips_pipeline_top (
		.clk(clk), .rst(rst), .debug_flag(debug_flag),
		.wea_ram_inst(wea_ram_inst), .imem_addr(imem_addr), .imem_data(imem_data),
		.dbg_reg_sel(dbg_reg_sel), .dbg_mem_en(dbg_mem_en), .dbg_mem_addr(dbg_mem_addr),
		.pc(pc), .dbg_reg_data(dbg_reg_data), .dbg_mem_data(dbg_mem_data),
		.halt_flag(halt_flag)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// hard stop if halt never shows up
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// instruction encoders
	//////////////////////////////////////////////////

	function automatic logic [31:0] enc_r(funct_e f, int rs, int rt, int rd, int sh);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], f};
	endfunction

	function automatic logic [31:0] enc_i(opcode_e op, int rs, int rt, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] enc_j(int idx);
		return {OP_J, idx[25:0]};
	endfunction

	task automatic build_program();
		// spare words hold addi r0 nops tagged with their index
		for (int i = 0; i < LOAD_WORDS; i++) begin
			prog[i] = enc_i(OP_ADDI, 0, 0, i);
		end
		// dependent chain where every result feeds the next one
		prog[0]  = enc_i(OP_ADDI, 0, 1, 7);
		prog[1]  = enc_i(OP_ADDI, 0, 2, 3);
		prog[2]  = enc_r(F_ADD, 1, 2, 3, 0);
		prog[3]  = enc_r(F_SUB, 3, 1, 4, 0);
		prog[4]  = enc_r(F_AND, 4, 3, 5, 0);
		prog[5]  = enc_r(F_OR, 5, 1, 6, 0);
		prog[6]  = enc_r(F_SLT, 2, 6, 7, 0);
		prog[7]  = enc_r(F_SLL, 0, 7, 8, 4);
		// store, load, then use right away
		prog[8]  = enc_i(OP_SW, 0, 3, 8);
		prog[9]  = enc_i(OP_LW, 0, 9, 8);
		prog[10] = enc_r(F_ADD, 9, 8, 10, 0);
		// taken branch to word 14
		prog[11] = enc_i(OP_BEQ, 1, 1, 2);
		prog[12] = enc_i(OP_ADDI, 0, 1, 99);
		prog[13] = enc_i(OP_ADDI, 0, 2, 99);
		prog[14] = enc_j(16);
		prog[15] = enc_i(OP_ADDI, 0, 3, 99);
		prog[16] = enc_i(OP_ADDI, 0, 15, 88);
		prog[17] = enc_i(OP_ADDI, 0, 16, -4);
		// write to r0 must vanish
		prog[18] = enc_r(F_ADD, 1, 2, 0, 0);
		// jr to word 22 with r15 from the writeback bypass
		prog[19] = enc_r(F_JR, 15, 0, 0, 0);
		prog[20] = enc_i(OP_ADDI, 0, 4, 99);
		prog[21] = enc_i(OP_ADDI, 0, 5, 99);
		prog[22] = enc_i(OP_ADDI, 15, 19, 1);
		prog[23] = enc_i(OP_SW, 0, 19, 4);
		prog[24] = {OP_HALT, 26'd0};
	endtask

	// architectural results in program order
	task automatic build_expected();
		for (int i = 0; i < `MIPS_REG_NUM; i++) begin
			exp_reg[i]   = '0;
			reg_known[i] = 1'b0;
		end
		for (int i = 0; i < MEM_CHECK; i++) begin
			exp_mem[i]   = '0;
			mem_known[i] = 1'b0;
		end
		exp_reg[1]  = 32'd7;
		exp_reg[2]  = 32'd3;
		exp_reg[3]  = exp_reg[1] + exp_reg[2];
		exp_reg[4]  = exp_reg[3] - exp_reg[1];
		exp_reg[5]  = exp_reg[4] & exp_reg[3];
		exp_reg[6]  = exp_reg[5] | exp_reg[1];
		exp_reg[7]  = ($signed(exp_reg[2]) < $signed(exp_reg[6])) ? 32'd1 : 32'd0;
		exp_reg[8]  = exp_reg[7] << 4;
		exp_mem[2]  = exp_reg[3];
		exp_reg[9]  = exp_mem[2];
		exp_reg[10] = exp_reg[9] + exp_reg[8];
		exp_reg[15] = 32'd88;
		exp_reg[16] = 32'(-4);
		exp_reg[19] = exp_reg[15] + 32'd1;
		exp_mem[1]  = exp_reg[19];
		// cancelled 99 writes leave r1..r5 as above
		for (int i = 0; i <= 10; i++) begin
			reg_known[i] = 1'b1;
		end
		reg_known[15] = 1'b1;
		reg_known[16] = 1'b1;
		reg_known[19] = 1'b1;
		mem_known[1]  = 1'b1;
		mem_known[2]  = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// debug readback
	//////////////////////////////////////////////////

	task automatic check_reg(int r);
		@(posedge clk);
		dbg_reg_sel <= r[`MIPS_REG_AW-1:0];
		@(negedge clk);
		if (reg_known[r]) begin
			assert (dbg_reg_data == exp_reg[r]) else begin
				$display("ERROR: dbg_reg_data r%0d got %h expected %h",
					r, dbg_reg_data, exp_reg[r]);
				errors++;
			end
		end
	endtask

	// synchronous read shows the word one edge later
	task automatic check_mem(int w);
		@(posedge clk);
		dbg_mem_addr <= w * 4;
		@(posedge clk);
		@(negedge clk);
		if (mem_known[w]) begin
			assert (dbg_mem_data == exp_mem[w]) else begin
				$display("ERROR: dbg_mem_data word %0d got %h expected %h",
					w, dbg_mem_data, exp_mem[w]);
				errors++;
			end
		end
	endtask

	initial begin
		rst          = 1'b1;
		debug_flag   = 1'b1;
		wea_ram_inst = 1'b0;
		imem_addr    = '0;
		imem_data    = '0;
		dbg_reg_sel  = '0;
		dbg_mem_en   = 1'b0;
		dbg_mem_addr = '0;
		build_program();
		build_expected();

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (pc == '0) else begin
			$display("ERROR: pc after reset got %h expected %h", pc, 32'h0);
			errors++;
		end
		assert (halt_flag == 1'b0) else begin
			$display("ERROR: halt_flag after reset got %h expected %h", halt_flag, 1'b0);
			errors++;
		end

		// program load while the pipeline is held
		for (int i = 0; i < LOAD_WORDS; i++) begin
			@(posedge clk);
			wea_ram_inst <= 1'b1;
			imem_addr    <= i[`MIPS_IMEM_AW-1:0];
			imem_data    <= prog[i];
		end
		@(posedge clk);
		wea_ram_inst <= 1'b0;
		debug_flag   <= 1'b0;

		while (!halt_flag) begin
			@(negedge clk);
		end
		halt_pc = pc;

		for (int r = 0; r < `MIPS_REG_NUM; r++) begin
			check_reg(r);
		end
		@(posedge clk);
		dbg_mem_en <= 1'b1;
		for (int w = 0; w < MEM_CHECK; w++) begin
			check_mem(w);
		end
		@(posedge clk);
		dbg_mem_en <= 1'b0;
		@(negedge clk);

		// frozen since halt
		assert (pc == halt_pc && halt_flag) else begin
			$display("ERROR: pc got %h expected %h, halt_flag %h", pc, halt_pc, halt_flag);
			errors++;
		end

		sva_fails = i_mips_pipeline_top.u_mips_sva.fail_count;
		$display("run finished: %0d check errors, %0d assertion failures", errors, sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+hw
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_pipeline_top.sv
test/mips_sva.sv
test/mips_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := mips_tb
FILELIST   := compile.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_ARGS   := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
PASS_MSG   := All tests passed!

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
